//--- axi_consts.svh
// single-beat AXI4 only: len 0, INCR bursts, OKAY responses; SRAM_DEPTH must be a power of two
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// --------------------
// bus widths
`define AXI_DATA_W     64
`define AXI_ADDR_W     32
`define AXI_STRB_W     (`AXI_DATA_W / 8)   // one strobe per byte lane
`define AXI_LEN_W      8

// --------------------
// protocol encodings
`define AXI_BURST_INCR 2'b01               // only burst type issued
`define AXI_RESP_OKAY  2'b00               // slave never reports errors

// --------------------
// memory and fetch port
`define SRAM_DEPTH     256                 // in 64-bit words
`define FETCH_SIZE     2'd2                // 4-byte instruction fetch

`endif

//--- axi_pkg.sv
// shared types for the memory subsystem; widths follow axi_consts.svh
`include "axi_consts.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_W-1:0] addr_t;   // byte address
  typedef logic [`AXI_DATA_W-1:0] data_t;
  typedef logic [`AXI_STRB_W-1:0] strb_t;   // byte enables
  typedef logic [1:0]             size_t;   // log2 of bytes per beat
  typedef logic [`AXI_LEN_W-1:0]  len_t;    // beats minus one

  typedef enum logic [2:0] {
    BR_IDLE,
    BR_RD_ADDR,
    BR_RD_DATA,
    BR_WR_ADDR,
    BR_WR_DATA,
    BR_WR_RESP
  } bridge_state_t;

  typedef enum logic [1:0] {
    SL_IDLE,
    SL_RD_RESP,
    SL_WR_DATA,
    SL_WR_RESP
  } slave_state_t;

endpackage

//--- mem_req_arbiter.sv
// request path is combinational; owner is latched at bus_addr_ok, so only one transaction may be open
`timescale 1ns/1ps
`include "axi_consts.svh"

module mem_req_arbiter (
  input  logic                     i_aclk,
  input  logic                     i_rst_n,
  input  logic                     i_if_req,
  input  axi_pkg::addr_t           i_if_addr,
  output logic                     o_if_addr_ok,
  output logic                     o_if_data_ok,
  output logic [`AXI_DATA_W/2-1:0] o_if_rdata,
  input  logic                     i_mem_req,
  input  logic                     i_mem_wr,
  input  axi_pkg::size_t           i_mem_size,
  input  axi_pkg::addr_t           i_mem_addr,
  input  axi_pkg::strb_t           i_mem_wstrb,
  input  axi_pkg::data_t           i_mem_wdata,
  output logic                     o_mem_addr_ok,
  output logic                     o_mem_data_ok,
  output axi_pkg::data_t           o_mem_rdata,
  output logic                     o_bus_req,
  output logic                     o_bus_wr,
  output axi_pkg::size_t           o_bus_size,
  output axi_pkg::addr_t           o_bus_addr,
  output axi_pkg::strb_t           o_bus_wstrb,
  output axi_pkg::data_t           o_bus_wdata,
  input  logic                     i_bus_addr_ok,
  input  logic                     i_bus_data_ok,
  input  axi_pkg::data_t           i_bus_rdata
);
  import axi_pkg::*;

  localparam size_t FETCH_SZ = `FETCH_SIZE;

  logic rr_data;      // set when the data port has priority
  logic sel_data;     // current winner
  logic owner_data;   // port of the open transaction
  logic half_hi;      // fetch wants the upper word half
  logic txn_open;     // between addr_ok and data_ok

  // --------------------
  // request side
  assign sel_data    = i_mem_req && (!i_if_req || rr_data);
  assign o_bus_req   = i_if_req || i_mem_req;
  assign o_bus_wr    = sel_data && i_mem_wr;                  // fetch never writes
  assign o_bus_size  = sel_data ? i_mem_size : FETCH_SZ;
  assign o_bus_addr  = sel_data ? i_mem_addr : i_if_addr;
  assign o_bus_wstrb = sel_data ? i_mem_wstrb : '0;
  assign o_bus_wdata = sel_data ? i_mem_wdata : '0;

  assign o_if_addr_ok  = i_bus_addr_ok && !sel_data;
  assign o_mem_addr_ok = i_bus_addr_ok && sel_data;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rr_data    <= 1'b0;
      owner_data <= 1'b0;
    end else if (i_bus_addr_ok) begin
      owner_data <= sel_data;
      if (i_if_req && i_mem_req) begin
        rr_data <= ~rr_data;                                  // loser goes first next time
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_bus_addr_ok && !sel_data) begin
      half_hi <= i_if_addr[2];
    end
  end

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      txn_open <= 1'b0;
    end else if (i_bus_addr_ok) begin
      txn_open <= 1'b1;
    end else if (i_bus_data_ok) begin
      txn_open <= 1'b0;
    end
  end

  // --------------------
  // response side
  assign o_if_data_ok  = i_bus_data_ok && !owner_data;
  assign o_mem_data_ok = i_bus_data_ok && owner_data;
  assign o_if_rdata    = half_hi ? i_bus_rdata[`AXI_DATA_W-1:`AXI_DATA_W/2]
                                 : i_bus_rdata[`AXI_DATA_W/2-1:0];
  assign o_mem_rdata   = i_bus_rdata;

  // owner is overwritten only after its data_ok, so a response goes to one port
  a_one_owner: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(i_bus_data_ok && !txn_open) && !(i_bus_addr_ok && txn_open));

endmodule

//--- axi4_master_bridge.sv
// one transaction outstanding; request is captured at addr_ok and issued as a len-0 INCR burst
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi4_master_bridge (
  input  logic           i_aclk,
  input  logic           i_rst_n,
  input  logic           i_bus_req,
  input  logic           i_bus_wr,
  input  axi_pkg::size_t i_bus_size,
  input  axi_pkg::addr_t i_bus_addr,
  input  axi_pkg::strb_t i_bus_wstrb,
  input  axi_pkg::data_t i_bus_wdata,
  output logic           o_bus_addr_ok,
  output logic           o_bus_data_ok,
  output axi_pkg::data_t o_bus_rdata,
  output axi_pkg::addr_t o_awaddr,
  output axi_pkg::size_t o_awsize,
  output logic           o_awvalid,
  input  logic           i_awready,
  output axi_pkg::data_t o_wdata,
  output axi_pkg::strb_t o_wstrb,
  output logic           o_wlast,
  output logic           o_wvalid,
  input  logic           i_wready,
  input  logic           i_bvalid,
  input  logic [1:0]     i_bresp,
  output logic           o_bready,
  output axi_pkg::addr_t o_araddr,
  output axi_pkg::size_t o_arsize,
  output logic           o_arvalid,
  input  logic           i_arready,
  input  logic           i_rvalid,
  input  axi_pkg::data_t i_rdata,
  input  logic [1:0]     i_rresp,
  input  logic           i_rlast,
  output logic           o_rready
);
  import axi_pkg::*;

  localparam len_t BURST_LEN = '0;   // single beat

  bridge_state_t state;
  addr_t         addr_q;
  size_t         size_q;
  strb_t         strb_q;
  data_t         wdata_q;
  data_t         rdata_q;
  logic          aw_fire;
  logic          w_fire;
  logic          b_fire;
  logic          ar_fire;
  logic          r_fire;

  assign aw_fire = o_awvalid && i_awready;
  assign w_fire  = o_wvalid && i_wready;
  assign b_fire  = o_bready && i_bvalid;
  assign ar_fire = o_arvalid && i_arready;
  assign r_fire  = o_rready && i_rvalid;

  // --------------------
  // transaction FSM
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state <= BR_IDLE;
    end else begin
      case (state)
        BR_IDLE:    if (i_bus_req) state <= i_bus_wr ? BR_WR_ADDR : BR_RD_ADDR;
        BR_RD_ADDR: if (ar_fire) state <= BR_RD_DATA;
        BR_RD_DATA: if (r_fire) state <= BR_IDLE;
        BR_WR_ADDR: if (aw_fire) state <= BR_WR_DATA;
        BR_WR_DATA: if (w_fire) state <= BR_WR_RESP;
        BR_WR_RESP: if (b_fire) state <= BR_IDLE;
        default:    state <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (o_bus_addr_ok) begin
      addr_q  <= i_bus_addr;
      size_q  <= i_bus_size;
      strb_q  <= i_bus_wstrb;
      wdata_q <= i_bus_wdata;
    end
    if (r_fire) begin
      rdata_q <= i_rdata;
    end
  end

  // --------------------
  // AXI channels
  assign o_arvalid = (state == BR_RD_ADDR);
  assign o_araddr  = addr_q;
  assign o_arsize  = size_q;
  assign o_rready  = (state == BR_RD_DATA);
  assign o_awvalid = (state == BR_WR_ADDR);
  assign o_awaddr  = addr_q;
  assign o_awsize  = size_q;
  assign o_wvalid  = (state == BR_WR_DATA);
  assign o_wdata   = wdata_q;
  assign o_wstrb   = strb_q;
  assign o_wlast   = (BURST_LEN == '0);          // every beat is the last one
  assign o_bready  = (state == BR_WR_RESP);

  // requester side
  assign o_bus_addr_ok = (state == BR_IDLE) && i_bus_req;
  assign o_bus_data_ok = r_fire || b_fire;
  assign o_bus_rdata   = r_fire ? i_rdata : rdata_q;   // holds last read word afterwards

  a_ar_held: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_arvalid && !i_arready |=> o_arvalid);
  a_aw_held: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_awvalid && !i_awready |=> o_awvalid);
  a_w_held: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_wvalid && !i_wready |=> o_wvalid);
  a_r_single: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    r_fire |-> i_rlast && (i_rresp == `AXI_RESP_OKAY));
  a_b_okay: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    b_fire |-> (i_bresp == `AXI_RESP_OKAY));

endmodule

//--- axi4_sram_slave.sv
// one transaction at a time, single-beat only; addresses wrap modulo SRAM_DEPTH, always OKAY
`timescale 1ns/1ps
`include "axi_consts.svh"

module axi4_sram_slave (
  input  logic           i_aclk,
  input  logic           i_rst_n,
  input  axi_pkg::addr_t i_awaddr,
  input  axi_pkg::size_t i_awsize,
  input  logic           i_awvalid,
  output logic           o_awready,
  input  axi_pkg::data_t i_wdata,
  input  axi_pkg::strb_t i_wstrb,
  input  logic           i_wlast,
  input  logic           i_wvalid,
  output logic           o_wready,
  output logic           o_bvalid,
  output logic [1:0]     o_bresp,
  input  logic           i_bready,
  input  axi_pkg::addr_t i_araddr,
  input  axi_pkg::size_t i_arsize,
  input  logic           i_arvalid,
  output logic           o_arready,
  output logic           o_rvalid,
  output axi_pkg::data_t o_rdata,
  output logic [1:0]     o_rresp,
  output logic           o_rlast,
  input  logic           i_rready
);
  import axi_pkg::*;

  localparam int OFFS_W = $clog2(`AXI_STRB_W);   // byte offset bits
  localparam int IDX_W  = $clog2(`SRAM_DEPTH);

  data_t            mem [0:`SRAM_DEPTH-1];
  slave_state_t     state;
  logic [IDX_W-1:0] wr_idx;
  data_t            rdata_q;
  logic             ar_fire;
  logic             aw_fire;
  logic             w_fire;

  assign ar_fire = i_arvalid && o_arready;
  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid && o_wready;

  // --------------------
  // handshake FSM
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state <= SL_IDLE;
    end else begin
      case (state)
        SL_IDLE: begin
          if (ar_fire) begin
            state <= SL_RD_RESP;
          end else if (aw_fire) begin
            state <= SL_WR_DATA;
          end
        end
        SL_RD_RESP: if (i_rready) state <= SL_IDLE;
        SL_WR_DATA: if (w_fire) state <= SL_WR_RESP;
        SL_WR_RESP: if (i_bready) state <= SL_IDLE;
        default:    state <= SL_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rdata_q <= mem[i_araddr[OFFS_W +: IDX_W]];
    end
    if (aw_fire) begin
      wr_idx <= i_awaddr[OFFS_W +: IDX_W];
    end
  end

  // --------------------
  // storage
  initial begin
    for (int i = 0; i < `SRAM_DEPTH; i++) begin
      mem[i] = '0;   // memory comes up cleared
    end
  end

  always @(posedge i_aclk) begin
    if (w_fire) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  assign o_arready = (state == SL_IDLE);
  assign o_awready = (state == SL_IDLE) && !i_arvalid;   // read wins a tie
  assign o_wready  = (state == SL_WR_DATA);
  assign o_bvalid  = (state == SL_WR_RESP);
  assign o_bresp   = `AXI_RESP_OKAY;
  assign o_rvalid  = (state == SL_RD_RESP);
  assign o_rdata   = rdata_q;
  assign o_rresp   = `AXI_RESP_OKAY;
  assign o_rlast   = o_rvalid;                           // single beat

  a_wlast_beat: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    w_fire |-> i_wlast);
  a_addr_known: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(ar_fire && $isunknown({i_araddr, i_arsize})) &&
    !(aw_fire && $isunknown({i_awaddr, i_awsize})));

endmodule

//--- mem_subsystem_top.sv
// fetch and data ports share one AXI4 path; read data_ok 2 cycles and write 3 after addr_ok
`timescale 1ns/1ps
`include "axi_consts.svh"

module mem_subsystem_top (
  input  logic                     i_aclk,
  input  logic                     i_rst_n,
  input  logic                     i_if_req,
  input  axi_pkg::addr_t           i_if_addr,
  output logic                     o_if_addr_ok,
  output logic                     o_if_data_ok,
  output logic [`AXI_DATA_W/2-1:0] o_if_rdata,
  input  logic                     i_mem_req,
  input  logic                     i_mem_wr,
  input  axi_pkg::size_t           i_mem_size,
  input  axi_pkg::addr_t           i_mem_addr,
  input  axi_pkg::strb_t           i_mem_wstrb,
  input  axi_pkg::data_t           i_mem_wdata,
  output logic                     o_mem_addr_ok,
  output logic                     o_mem_data_ok,
  output axi_pkg::data_t           o_mem_rdata
);
  import axi_pkg::*;

  // --------------------
  // arbiter to bridge
  logic  bus_req, bus_wr;
  size_t bus_size;
  addr_t bus_addr;
  strb_t bus_wstrb;
  data_t bus_wdata, bus_rdata;
  logic  bus_addr_ok, bus_data_ok;

  // --------------------
  // AXI4 channels
  addr_t      awaddr, araddr;
  size_t      awsize, arsize;
  logic       awvalid, awready;
  data_t      wdata, rdata;
  strb_t      wstrb;
  logic       wlast, wvalid, wready;
  logic       bvalid, bready;
  logic [1:0] bresp, rresp;
  logic       arvalid, arready;
  logic       rvalid, rready, rlast;

  mem_req_arbiter u_arbiter (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_if_req(i_if_req), .i_if_addr(i_if_addr), .o_if_addr_ok(o_if_addr_ok),
    .o_if_data_ok(o_if_data_ok), .o_if_rdata(o_if_rdata),
    .i_mem_req(i_mem_req), .i_mem_wr(i_mem_wr), .i_mem_size(i_mem_size),
    .i_mem_addr(i_mem_addr), .i_mem_wstrb(i_mem_wstrb), .i_mem_wdata(i_mem_wdata),
    .o_mem_addr_ok(o_mem_addr_ok), .o_mem_data_ok(o_mem_data_ok), .o_mem_rdata(o_mem_rdata),
    .o_bus_req(bus_req), .o_bus_wr(bus_wr), .o_bus_size(bus_size), .o_bus_addr(bus_addr),
    .o_bus_wstrb(bus_wstrb), .o_bus_wdata(bus_wdata), .i_bus_addr_ok(bus_addr_ok),
    .i_bus_data_ok(bus_data_ok), .i_bus_rdata(bus_rdata)
  );

  axi4_master_bridge u_bridge (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_bus_req(bus_req), .i_bus_wr(bus_wr), .i_bus_size(bus_size), .i_bus_addr(bus_addr),
    .i_bus_wstrb(bus_wstrb), .i_bus_wdata(bus_wdata), .o_bus_addr_ok(bus_addr_ok),
    .o_bus_data_ok(bus_data_ok), .o_bus_rdata(bus_rdata),
    .o_awaddr(awaddr), .o_awsize(awsize), .o_awvalid(awvalid), .i_awready(awready),
    .o_wdata(wdata), .o_wstrb(wstrb), .o_wlast(wlast), .o_wvalid(wvalid), .i_wready(wready),
    .i_bvalid(bvalid), .i_bresp(bresp), .o_bready(bready),
    .o_araddr(araddr), .o_arsize(arsize), .o_arvalid(arvalid), .i_arready(arready),
    .i_rvalid(rvalid), .i_rdata(rdata), .i_rresp(rresp), .i_rlast(rlast), .o_rready(rready)
  );

  axi4_sram_slave u_sram (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_awaddr(awaddr), .i_awsize(awsize), .i_awvalid(awvalid), .o_awready(awready),
    .i_wdata(wdata), .i_wstrb(wstrb), .i_wlast(wlast), .i_wvalid(wvalid), .o_wready(wready),
    .o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
    .i_araddr(araddr), .i_arsize(arsize), .i_arvalid(arvalid), .o_arready(arready),
    .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .o_rlast(rlast), .i_rready(rready)
  );

endmodule

//--- tb_mem_subsystem.sv
// drives on falling edges and samples 1 ns later; the model assumes one transaction in flight
`timescale 1ns/1ps
`include "axi_consts.svh"

module tb_mem_subsystem;
  import axi_pkg::*;

  logic        i_aclk, i_rst_n;
  logic        i_if_req, i_mem_req, i_mem_wr;
  addr_t       i_if_addr, i_mem_addr;
  size_t       i_mem_size;
  strb_t       i_mem_wstrb;
  data_t       i_mem_wdata, o_mem_rdata;
  logic        o_if_addr_ok, o_if_data_ok, o_mem_addr_ok, o_mem_data_ok;
  logic [31:0] o_if_rdata;

  data_t       model [0:`SRAM_DEPTH-1];       // mirror of the slave memory
  addr_t       wr_addrs [0:23];               // addresses written by the write/read test
  logic [31:0] lcg_state;
  string       test_name;
  int          cyc, errors, checks, test_errs, test_checks, gen_left, last_both;
  bit          timed_out;
  logic        if_pend, mem_pend, mem_wr_r;   // request held until its addr_ok
  addr_t       if_addr_r, mem_addr_r;
  strb_t       mem_strb_r;
  data_t       mem_wdata_r;
  int          if_wait, mem_wait;
  data_t       if_exp_q[$], mem_exp_q[$];     // expected data per accepted request
  int          if_cyc_q[$], mem_cyc_q[$];     // cycle of each addr_ok
  bit          mem_wr_q[$];

  mem_subsystem_top DUT (.*);

  always #5 i_aclk = ~i_aclk;

  // --------------------
  // helpers
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand32();
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    return {a[31:16], b[31:16]};   // upper halves only, low LCG bits are weak
  endfunction

  function automatic int word_index(input addr_t a);
    return int'(a >> 3) % `SRAM_DEPTH;   // 8-byte words, wrapping at the memory size
  endfunction

  task automatic value_error(input string what, input data_t exp, input data_t act);
    $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
    test_errs++;
  endtask

  task automatic report(input string msg);
    $display("%s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic flag_timeout(input string msg);
    report({"timeout, ", msg});
    timed_out = 1'b1;
  endtask

  task automatic queue_fetch(input addr_t a);
    if_pend   = 1'b1;
    if_addr_r = a & ~addr_t'(3);
  endtask

  task automatic queue_data(input bit wr, input addr_t a, input strb_t s, input data_t d);
    mem_pend    = 1'b1;
    mem_wr_r    = wr;
    mem_addr_r  = a & ~addr_t'(7);
    mem_strb_r  = wr ? s : '0;
    mem_wdata_r = d;
  endtask

  task automatic make_requests();
    logic [31:0] r;
    if (gen_left > 0 && !if_pend) begin
      queue_fetch(rand32());
      gen_left--;
    end
    if (gen_left > 0 && !mem_pend) begin
      r = rand32();
      queue_data(r[0], rand32(), r[15:8], {rand32(), rand32()});
      gen_left--;
    end
  endtask

  // --------------------
  // one clock cycle: drive, sample, check
  task automatic step();
    data_t exp;
    int    lat;
    int    idx;
    int    b;
    bit    wr;
    @(negedge i_aclk);
    make_requests();
    i_if_req    = if_pend;
    i_if_addr   = if_addr_r;
    i_mem_req   = mem_pend;
    i_mem_wr    = mem_wr_r;
    i_mem_addr  = mem_addr_r;
    i_mem_wstrb = mem_strb_r;
    i_mem_wdata = mem_wdata_r;
    #1;
    cyc++;
    if (o_if_data_ok && o_mem_data_ok) report("data_ok reached both ports");
    if (o_if_data_ok) begin
      if (if_exp_q.size() == 0) begin
        report("fetch data_ok with no fetch in flight");
      end else begin
        lat = cyc - if_cyc_q.pop_front();
        exp = if_exp_q.pop_front();
        test_checks += 2;
        if (lat != 2) value_error("fetch latency", data_t'(2), data_t'(lat));
        if (o_if_rdata !== exp[31:0]) value_error("fetch rdata", exp, data_t'(o_if_rdata));
      end
    end
    if (o_mem_data_ok) begin
      if (mem_exp_q.size() == 0) begin
        report("data-port data_ok with no access in flight");
      end else begin
        lat = cyc - mem_cyc_q.pop_front();
        exp = mem_exp_q.pop_front();
        wr  = mem_wr_q.pop_front();
        test_checks += 2;
        if (lat != (wr ? 3 : 2)) value_error("data latency", data_t'(wr ? 3 : 2), data_t'(lat));
        if (!wr && o_mem_rdata !== exp) value_error("data rdata", exp, o_mem_rdata);
      end
    end
    if ((o_if_addr_ok || o_mem_addr_ok) && if_pend && mem_pend) begin
      if (last_both == int'(o_mem_addr_ok)) report("same port granted twice under contention");
      last_both = int'(o_mem_addr_ok);
    end
    if (o_if_addr_ok) begin
      if (!if_pend) report("fetch addr_ok without a request");
      exp = model[word_index(if_addr_r)];
      if_exp_q.push_back(data_t'(if_addr_r[2] ? exp[63:32] : exp[31:0]));
      if_cyc_q.push_back(cyc);
      if_pend = 1'b0;
    end
    if (o_mem_addr_ok) begin
      if (!mem_pend) report("data-port addr_ok without a request");
      idx = word_index(mem_addr_r);
      for (b = 0; b < `AXI_STRB_W; b++) begin
        if (mem_wr_r && mem_strb_r[b]) model[idx][8*b +: 8] = mem_wdata_r[8*b +: 8];
      end
      mem_exp_q.push_back(model[idx]);
      mem_cyc_q.push_back(cyc);
      mem_wr_q.push_back(mem_wr_r);
      mem_pend = 1'b0;
    end
    if_wait  = if_pend ? if_wait + 1 : 0;
    mem_wait = mem_pend ? mem_wait + 1 : 0;
    if (if_wait > 40) flag_timeout("fetch request never got addr_ok");
    if (mem_wait > 40) flag_timeout("data request never got addr_ok");
    if (if_cyc_q.size() > 0 && cyc - if_cyc_q[0] > 8) flag_timeout("fetch data_ok never came");
    if (mem_cyc_q.size() > 0 && cyc - mem_cyc_q[0] > 8) flag_timeout("data_ok never came");
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (!timed_out && n < 5000 && (if_pend || mem_pend || gen_left > 0 ||
           if_exp_q.size() > 0 || mem_exp_q.size() > 0)) begin
      step();
      n++;
    end
    if (n >= 5000) flag_timeout("traffic did not drain");
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errs   = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errs);
    errors += test_errs;
    checks += test_checks;
  endtask

  // --------------------
  // test sequence
  initial begin
    int    i;
    addr_t a;
    i_aclk      = 1'b0;
    i_rst_n     = 1'b0;
    i_if_req    = 1'b0;
    i_if_addr   = '0;
    i_mem_req   = 1'b0;
    i_mem_wr    = 1'b0;
    i_mem_size  = 2'd3;   // full 8-byte accesses
    i_mem_addr  = '0;
    i_mem_wstrb = '0;
    i_mem_wdata = '0;
    lcg_state   = 32'd85384;
    {if_pend, mem_pend, mem_wr_r, timed_out} = '0;
    {if_addr_r, mem_addr_r, mem_strb_r, mem_wdata_r} = '0;
    {cyc, errors, checks, gen_left, if_wait, mem_wait} = '0;
    last_both = -1;
    for (i = 0; i < `SRAM_DEPTH; i++) model[i] = '0;
    repeat (2) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst_n = 1'b1;

    start_test("reset");
    step();
    test_checks++;
    if (o_if_addr_ok || o_if_data_ok || o_mem_addr_ok || o_mem_data_ok) begin
      report("handshake strobe high in the first cycle after reset");
    end
    end_test();

    start_test("write_read");
    for (i = 0; i < 24 && !timed_out; i++) begin
      a = rand32();
      wr_addrs[i] = a;
      queue_data(1'b1, a, strb_t'(rand32()), {rand32(), rand32()});
      drain();
      queue_data(1'b0, a, '0, '0);
      drain();
      queue_data(1'b0, a + `SRAM_DEPTH * 8, '0, '0);   // alias of the same word
      drain();
    end
    end_test();

    start_test("fetch");
    for (i = 0; i < 24 && !timed_out; i++) begin
      queue_fetch(wr_addrs[i]);
      drain();
      queue_fetch(wr_addrs[i] | addr_t'(4));           // upper half
      drain();
    end
    end_test();

    start_test("latency");
    for (i = 0; i < 16 && !timed_out; i++) begin
      queue_fetch(rand32());
      queue_data(i[0], rand32(), 8'hff, {rand32(), rand32()});
      drain();
    end
    end_test();

    start_test("contention");
    gen_left = 200;
    drain();
    end_test();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
axi_pkg.sv
mem_req_arbiter.sv
axi4_master_bridge.sv
axi4_sram_slave.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem -f list.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_mem_subsystem > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
